// File: hw/mipsPkg.sv
package mipsPkg;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFmtT;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } iFmtT;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target26;
    } jFmtT;

    // one instruction word, three field layouts
    typedef union packed {
        rFmtT r;
        iFmtT i;
        jFmtT j;
    } instrT;

    localparam logic [31:0] defResetPc = 32'h0000_3000;
    localparam int          defDmWords = 1024;

    localparam logic [2:0] aluAdd = 3'b000;
    localparam logic [2:0] aluSub = 3'b001;
    localparam logic [2:0] aluXor = 3'b010;
    localparam logic [2:0] aluOr  = 3'b011;
    localparam logic [2:0] aluSll = 3'b100;

    localparam logic [2:0] wbAlu  = 3'b000;
    localparam logic [2:0] wbMem  = 3'b001;
    localparam logic [2:0] wbLui  = 3'b010;
    localparam logic [2:0] wbLink = 3'b011; // pc+4

    localparam logic [2:0] extZero  = 3'b000;
    localparam logic [2:0] extSign  = 3'b001;
    localparam logic [2:0] extUpper = 3'b010;

    localparam logic [1:0] dstRt = 2'b00;
    localparam logic [1:0] dstRd = 2'b01;
    localparam logic [1:0] dstRa = 2'b10;

    localparam logic [2:0] npcSeq    = 3'b000;
    localparam logic [2:0] npcBranch = 3'b001;
    localparam logic [2:0] npcJump   = 3'b010;
    localparam logic [2:0] npcReg    = 3'b100;

    localparam logic [1:0] memWord = 2'b00;
    localparam logic [1:0] memHalf = 2'b01;
    localparam logic [1:0] memByte = 2'b10;

    localparam logic [5:0] opSpecial = 6'b000000;
    localparam logic [5:0] opRegimm  = 6'b000001; // bgezal, rt not checked
    localparam logic [5:0] opJ       = 6'b000010;
    localparam logic [5:0] opJal     = 6'b000011;
    localparam logic [5:0] opBeq     = 6'b000100;
    localparam logic [5:0] opBgtz    = 6'b000111;
    localparam logic [5:0] opAddi    = 6'b001000;
    localparam logic [5:0] opOri     = 6'b001101;
    localparam logic [5:0] opLui     = 6'b001111;
    localparam logic [5:0] opLb      = 6'b100000;
    localparam logic [5:0] opLh      = 6'b100001;
    localparam logic [5:0] opLw      = 6'b100011;
    localparam logic [5:0] opSb      = 6'b101000;
    localparam logic [5:0] opSh      = 6'b101001;
    localparam logic [5:0] opSw      = 6'b101011;

    localparam logic [5:0] fnSll  = 6'b000000;
    localparam logic [5:0] fnJr   = 6'b001000;
    localparam logic [5:0] fnJalr = 6'b001001;
    localparam logic [5:0] fnAdd  = 6'b100000;
    localparam logic [5:0] fnAddu = 6'b100001;
    localparam logic [5:0] fnSub  = 6'b100010;
    localparam logic [5:0] fnXor  = 6'b100110;

endpackage

// File: hw/controller.sv
`timescale 1ns/1ps

module controller (
    input  logic [5:0] opcode,
    input  logic [5:0] funct,
    output logic [2:0] aluCtrl,
    output logic       memRead,
    output logic       memWrite,
    output logic       regWrite,
    output logic [2:0] wbSel,
    output logic [2:0] extSel,
    output logic       aluSrc,
    output logic [1:0] regDst,
    output logic [2:0] npcSel,
    output logic       isBeq,
    output logic       isBgtz,
    output logic       isBgezal,
    output logic [1:0] memSize
);
    import mipsPkg::*;

    logic rType;
    logic insAdd, insSub, insXor, insSll, insJr, insJalr;
    logic insOri, insAddi, insLui;
    logic insLw, insLh, insLb, insSw, insSh, insSb;
    logic insBeq, insBgtz, insBgezal, insJ, insJal;
    logic load, store, branch, link;

    assign rType   = (opcode == opSpecial);
    assign insAdd  = rType & ((funct == fnAdd) | (funct == fnAddu)); // no overflow trap
    assign insSub  = rType & (funct == fnSub);
    assign insXor  = rType & (funct == fnXor);
    assign insSll  = rType & (funct == fnSll);
    assign insJr   = rType & (funct == fnJr);
    assign insJalr = rType & (funct == fnJalr);

    assign insOri    = (opcode == opOri);
    assign insAddi   = (opcode == opAddi);
    assign insLui    = (opcode == opLui);
    assign insLw     = (opcode == opLw);
    assign insLh     = (opcode == opLh);
    assign insLb     = (opcode == opLb);
    assign insSw     = (opcode == opSw);
    assign insSh     = (opcode == opSh);
    assign insSb     = (opcode == opSb);
    assign insBeq    = (opcode == opBeq);
    assign insBgtz   = (opcode == opBgtz);
    assign insBgezal = (opcode == opRegimm);
    assign insJ      = (opcode == opJ);
    assign insJal    = (opcode == opJal);

    assign load   = insLw | insLh | insLb;
    assign store  = insSw | insSh | insSb;
    assign branch = insBeq | insBgtz | insBgezal;
    assign link   = insJal | insJalr | insBgezal; // bgezal links even when not taken

    assign aluCtrl = insSub ? aluSub :
                     insXor ? aluXor :
                     insOri ? aluOr  :
                     insSll ? aluSll :
                     aluAdd;

    assign memRead  = load;
    assign memWrite = store;
    assign regWrite = insAdd | insSub | insXor | insSll | insOri | insAddi
                    | insLui | load | link;

    assign wbSel = load   ? wbMem  :
                   insLui ? wbLui  :
                   link   ? wbLink :
                   wbAlu;

    assign extSel = (load | store | branch | insAddi) ? extSign :
                    insLui ? extUpper :
                    extZero;

    assign aluSrc = insOri | insAddi | insLui | load | store;

    assign regDst = (insAdd | insSub | insXor | insSll | insJalr) ? dstRd :
                    (insJal | insBgezal) ? dstRa :
                    dstRt;

    assign npcSel = branch            ? npcBranch :
                    (insJ | insJal)   ? npcJump   :
                    (insJr | insJalr) ? npcReg    :
                    npcSeq;

    assign isBeq    = insBeq;
    assign isBgtz   = insBgtz;
    assign isBgezal = insBgezal;

    assign memSize = (insLh | insSh) ? memHalf :
                     (insLb | insSb) ? memByte :
                     memWord;

endmodule

// File: hw/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic        clk,
    input  logic        rstN,
    input  logic [4:0]  rs,
    input  logic [4:0]  rt,
    input  logic        we,
    input  logic [4:0]  wa,
    input  logic [31:0] wd,
    output logic [31:0] rsVal,
    output logic [31:0] rtVal
);

    logic [31:0] regs [1:31]; // $0 has no storage

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int n = 1; n < 32; n++) begin
                regs[n] <= '0;
            end
        end else if (we && (wa != 5'd0)) begin
            regs[wa] <= wd;
        end
    end

    assign rsVal = (rs == 5'd0) ? 32'd0 : regs[rs];
    assign rtVal = (rt == 5'd0) ? 32'd0 : regs[rt];

endmodule

// File: hw/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic [4:0]  shamt,
    input  logic [2:0]  aluCtrl,
    output logic [31:0] y
);
    import mipsPkg::*;

    always_comb begin
        case (aluCtrl)
            aluAdd:  y = a + b; // wraps
            aluSub:  y = a - b;
            aluXor:  y = a ^ b;
            aluOr:   y = a | b;
            aluSll:  y = b << shamt; // sll shifts rt
            default: y = a + b;
        endcase
    end

endmodule

// File: hw/nextPc.sv
`timescale 1ns/1ps

module nextPc #(
    parameter logic [31:0] resetPc = mipsPkg::defResetPc
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic [2:0]  npcSel,
    input  logic        isBeq,
    input  logic        isBgtz,
    input  logic        isBgezal,
    input  logic [31:0] rsVal,
    input  logic [31:0] rtVal,
    input  logic [15:0] imm16,
    input  logic [25:0] target26,
    output logic [31:0] pc,
    output logic [31:0] pcPlus4
);
    import mipsPkg::*;

    logic        taken;
    logic [31:0] brTarget;
    logic [31:0] jTarget;
    logic [31:0] npc;

    assign pcPlus4 = pc + 32'd4;

    assign taken = (isBeq    & (rsVal == rtVal))
                 | (isBgtz   & ($signed(rsVal) > 0))
                 | (isBgezal & ~rsVal[31]); // rs >= 0

    assign brTarget = pcPlus4 + {{14{imm16[15]}}, imm16, 2'b00};
    assign jTarget  = {pcPlus4[31:28], target26, 2'b00};

    always_comb begin
        case (npcSel)
            npcBranch: npc = taken ? brTarget : pcPlus4;
            npcJump:   npc = jTarget;
            npcReg:    npc = rsVal;
            default:   npc = pcPlus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= resetPc;
        end else begin
            pc <= npc;
        end
    end

endmodule

// File: hw/dataMem.sv
`timescale 1ns/1ps

module dataMem #(
    parameter int dmWords = mipsPkg::defDmWords
) (
    input  logic        clk,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    input  logic        we,
    input  logic        re,
    input  logic [1:0]  memSize,
    output logic [31:0] rdata
);
    import mipsPkg::*;

    localparam int aw = $clog2(dmWords);

    logic [31:0]   mem [0:dmWords-1];
    logic [aw-1:0] wordIdx;
    logic [3:0]    byteEn;
    logic [31:0]   laneData;
    logic [31:0]   word;
    logic [15:0]   half;
    logic [7:0]    byteVal;

    assign wordIdx = addr[aw+1:2];
    assign word    = mem[wordIdx];

    always_comb begin
        case (memSize)
            memHalf: begin
                byteEn   = addr[1] ? 4'b1100 : 4'b0011;
                laneData = {2{wdata[15:0]}};
            end
            memByte: begin
                byteEn   = 4'b0001 << addr[1:0];
                laneData = {4{wdata[7:0]}};
            end
            default: begin
                byteEn   = 4'b1111;
                laneData = wdata;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < 4; b++) begin
                if (byteEn[b]) mem[wordIdx][8*b +: 8] <= laneData[8*b +: 8];
            end
        end
    end

    assign half    = addr[1] ? word[31:16] : word[15:0];
    assign byteVal = word[8*addr[1:0] +: 8];

    always_comb begin
        if (!re) begin
            rdata = '0;
        end else begin
            case (memSize)
                memHalf: rdata = {{16{half[15]}}, half};
                memByte: rdata = {{24{byteVal[7]}}, byteVal};
                default: rdata = word;
            endcase
        end
    end

endmodule

// File: hw/mipsCore.sv
`timescale 1ns/1ps

module mipsCore #(
    parameter logic [31:0] resetPc = mipsPkg::defResetPc,
    parameter int          dmWords = mipsPkg::defDmWords
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic [31:0] instr,
    output logic [31:0] pc,
    output logic        wbEn,
    output logic [4:0]  wbReg,
    output logic [31:0] wbData
);
    import mipsPkg::*;

    instrT ins;

    logic [2:0]  aluCtrl;
    logic        memRead;
    logic        memWrite;
    logic        regWrite;
    logic [2:0]  wbSel;
    logic [2:0]  extSel;
    logic        aluSrc;
    logic [1:0]  regDst;
    logic [2:0]  npcSel;
    logic        isBeq;
    logic        isBgtz;
    logic        isBgezal;
    logic [1:0]  memSize;

    logic [31:0] rsVal;
    logic [31:0] rtVal;
    logic [31:0] extImm;
    logic [31:0] aluB;
    logic [31:0] aluY;
    logic [31:0] memData;
    logic [31:0] pcPlus4;

    assign ins = instr;

    controller controller_i (
        .opcode   (ins.r.opcode),
        .funct    (ins.r.funct),
        .aluCtrl  (aluCtrl),
        .memRead  (memRead),
        .memWrite (memWrite),
        .regWrite (regWrite),
        .wbSel    (wbSel),
        .extSel   (extSel),
        .aluSrc   (aluSrc),
        .regDst   (regDst),
        .npcSel   (npcSel),
        .isBeq    (isBeq),
        .isBgtz   (isBgtz),
        .isBgezal (isBgezal),
        .memSize  (memSize)
    );

    always_comb begin
        case (extSel)
            extSign:  extImm = {{16{ins.i.imm16[15]}}, ins.i.imm16};
            extUpper: extImm = {ins.i.imm16, 16'd0}; // lui value
            default:  extImm = {16'd0, ins.i.imm16};
        endcase
    end

    assign aluB = aluSrc ? extImm : rtVal;

    alu alu_i (
        .a       (rsVal),
        .b       (aluB),
        .shamt   (ins.r.shamt),
        .aluCtrl (aluCtrl),
        .y       (aluY)
    );

    always_comb begin
        case (regDst)
            dstRd:   wbReg = ins.r.rd;
            dstRa:   wbReg = 5'd31;
            default: wbReg = ins.r.rt;
        endcase
    end

    always_comb begin
        case (wbSel)
            wbMem:   wbData = memData;
            wbLui:   wbData = extImm;
            wbLink:  wbData = pcPlus4;
            default: wbData = aluY;
        endcase
    end

    assign wbEn = regWrite & rstN; // quiet while in reset

    regFile regFile_i (
        .clk   (clk),
        .rstN  (rstN),
        .rs    (ins.r.rs),
        .rt    (ins.r.rt),
        .we    (wbEn),
        .wa    (wbReg),
        .wd    (wbData),
        .rsVal (rsVal),
        .rtVal (rtVal)
    );

    dataMem #(
        .dmWords (dmWords)
    ) dataMem_i (
        .clk     (clk),
        .addr    (aluY),
        .wdata   (rtVal),
        .we      (memWrite & rstN),
        .re      (memRead),
        .memSize (memSize),
        .rdata   (memData)
    );

    nextPc #(
        .resetPc (resetPc)
    ) nextPc_i (
        .clk      (clk),
        .rstN     (rstN),
        .npcSel   (npcSel),
        .isBeq    (isBeq),
        .isBgtz   (isBgtz),
        .isBgezal (isBgezal),
        .rsVal    (rsVal),
        .rtVal    (rtVal),
        .imm16    (ins.i.imm16),
        .target26 (ins.j.target26),
        .pc       (pc),
        .pcPlus4  (pcPlus4)
    );

endmodule

// File: bench/mipsCoreTb.sv
`timescale 1ns/1ps

module mipsCoreTb;
    import mipsPkg::*;

    localparam logic [31:0] bootPc = 32'h0000_3000;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic        en;
        logic [4:0]  rg;
        logic [31:0] data;
    } stepT;

    logic        clk;
    logic        rstN;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        wbEn;
    logic [4:0]  wbReg;
    logic [31:0] wbData;

    stepT        prog [$];
    logic [31:0] model [0:31]; // expected register contents
    logic [31:0] curPc;

    mipsCore mipsCore_i (
        .clk    (clk),
        .rstN   (rstN),
        .instr  (instr),
        .pc     (pc),
        .wbEn   (wbEn),
        .wbReg  (wbReg),
        .wbData (wbData)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] encR(input logic [5:0] fn, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [4:0] rd,
                                         input logic [4:0] sh);
        instrT w;
        w.r.opcode = opSpecial;
        w.r.rs     = rs;
        w.r.rt     = rt;
        w.r.rd     = rd;
        w.r.shamt  = sh;
        w.r.funct  = fn;
        return w;
    endfunction

    function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
        instrT w;
        w.i.opcode = op;
        w.i.rs     = rs;
        w.i.rt     = rt;
        w.i.imm16  = imm;
        return w;
    endfunction

    function automatic logic [31:0] encJ(input logic [5:0] op, input logic [25:0] target);
        instrT w;
        w.j.opcode   = op;
        w.j.target26 = target;
        return w;
    endfunction

    task automatic stopOnError();
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkWord(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("** Error: %s expected %h, got %h", name, exp, act);
            stopOnError();
        end
    endtask

    task automatic checkReg(input string name, input logic [4:0] exp, input logic [4:0] act);
        if (act !== exp) begin
            $display("** Error: %s expected %h, got %h", name, exp, act);
            stopOnError();
        end
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error: %s expected %h, got %h", name, exp, act);
            stopOnError();
        end
    endtask

    task automatic addStep(input logic [31:0] ins, input logic en, input logic [4:0] rg,
                           input logic [31:0] data, input logic [31:0] npc);
        stepT s;
        s.instr = ins;
        s.pc    = curPc;
        s.en    = en;
        s.rg    = rg;
        s.data  = data;
        prog.push_back(s);
        if (en && (rg != 5'd0)) model[rg] = data;
        curPc = npc;
    endtask

    task automatic addSeq(input logic [31:0] ins, input logic en, input logic [4:0] rg,
                          input logic [31:0] data);
        addStep(ins, en, rg, data, curPc + 32'd4);
    endtask

    task automatic buildProgram();
        logic [31:0] rnd;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        curPc = bootPc;
        foreach (model[n]) model[n] = '0;
        addSeq(encI(opLui, 5'd0, 5'd1, 16'h1234), 1'b1, 5'd1, 32'h1234_0000);
        addSeq(encI(opOri, 5'd1, 5'd1, 16'h5678), 1'b1, 5'd1, 32'h1234_5678);
        addSeq(encI(opLui, 5'd0, 5'd2, 16'h8000), 1'b1, 5'd2, 32'h8000_0000);
        addSeq(encI(opOri, 5'd2, 5'd2, 16'hFFFF), 1'b1, 5'd2, 32'h8000_FFFF);
        addSeq(encI(opAddi, 5'd2, 5'd3, 16'hFFFF), 1'b1, 5'd3, 32'h8000_FFFE); // -1
        addSeq(encI(opAddi, 5'd0, 5'd4, 16'h0001), 1'b1, 5'd4, 32'h0000_0001);
        addSeq(encI(opLui, 5'd0, 5'd5, 16'h7FFF), 1'b1, 5'd5, 32'h7FFF_0000);
        addSeq(encI(opOri, 5'd5, 5'd5, 16'hFFFF), 1'b1, 5'd5, 32'h7FFF_FFFF);
        addSeq(encR(fnAdd, 5'd5, 5'd4, 5'd6, 5'd0), 1'b1, 5'd6, 32'h8000_0000); // wraps
        addSeq(encR(fnAddu, 5'd6, 5'd6, 5'd23, 5'd0), 1'b1, 5'd23, 32'h0000_0000);
        addSeq(encR(fnSub, 5'd4, 5'd5, 5'd7, 5'd0), 1'b1, 5'd7, 32'h8000_0002);
        addSeq(encR(fnXor, 5'd1, 5'd2, 5'd8, 5'd0), 1'b1, 5'd8, 32'h9234_A987);
        addSeq(encR(fnSll, 5'd0, 5'd1, 5'd9, 5'd4), 1'b1, 5'd9, 32'h2345_6780);
        addSeq(encI(opAddi, 5'd0, 5'd0, 16'h0005), 1'b1, 5'd0, 32'h0000_0005); // $0 target
        addSeq(encR(fnXor, 5'd0, 5'd1, 5'd10, 5'd0), 1'b1, 5'd10, 32'h1234_5678);
        // memory lanes, word at 0x100
        addSeq(encI(opSw, 5'd0, 5'd1, 16'h0100), 1'b0, 5'd0, 32'd0);
        addSeq(encI(opLw, 5'd0, 5'd11, 16'h0100), 1'b1, 5'd11, 32'h1234_5678);
        addSeq(encI(opLh, 5'd0, 5'd12, 16'h0102), 1'b1, 5'd12, 32'h0000_1234);
        addSeq(encI(opLh, 5'd0, 5'd13, 16'h0100), 1'b1, 5'd13, 32'h0000_5678);
        addSeq(encI(opLb, 5'd0, 5'd14, 16'h0101), 1'b1, 5'd14, 32'h0000_0056);
        addSeq(encI(opSb, 5'd0, 5'd2, 16'h0103), 1'b0, 5'd0, 32'd0); // 0xff to top lane
        addSeq(encI(opLb, 5'd0, 5'd15, 16'h0103), 1'b1, 5'd15, 32'hFFFF_FFFF);
        addSeq(encI(opLh, 5'd0, 5'd16, 16'h0102), 1'b1, 5'd16, 32'hFFFF_FF34);
        addSeq(encI(opSh, 5'd0, 5'd3, 16'h0100), 1'b0, 5'd0, 32'd0);
        addSeq(encI(opLw, 5'd0, 5'd17, 16'h0100), 1'b1, 5'd17, 32'hFF34_FFFE);
        addSeq(encI(opLb, 5'd0, 5'd18, 16'h0100), 1'b1, 5'd18, 32'hFFFF_FFFE);
        addSeq(encI(opLb, 5'd0, 5'd19, 16'h0102), 1'b1, 5'd19, 32'h0000_0034);
        addSeq(encI(opSh, 5'd0, 5'd1, 16'h0106), 1'b0, 5'd0, 32'd0);
        addSeq(encI(opLh, 5'd0, 5'd24, 16'h0106), 1'b1, 5'd24, 32'h0000_5678);
        // branches
        addStep(encI(opBeq, 5'd1, 5'd1, 16'h0002), 1'b0, 5'd0, 32'd0, curPc + 32'd12);
        addStep(encI(opBeq, 5'd1, 5'd2, 16'h0005), 1'b0, 5'd0, 32'd0, curPc + 32'd4);
        addStep(encI(opBgtz, 5'd4, 5'd0, 16'h0003), 1'b0, 5'd0, 32'd0, curPc + 32'd16);
        addStep(encI(opBgtz, 5'd0, 5'd0, 16'h0003), 1'b0, 5'd0, 32'd0, curPc + 32'd4);
        addStep(encI(opBgtz, 5'd2, 5'd0, 16'h0003), 1'b0, 5'd0, 32'd0, curPc + 32'd4);
        addStep(encI(opRegimm, 5'd4, 5'd17, 16'h0002), 1'b1, 5'd31, curPc + 32'd4,
                curPc + 32'd12);
        addStep(encI(opRegimm, 5'd2, 5'd17, 16'h0002), 1'b1, 5'd31, curPc + 32'd4,
                curPc + 32'd4); // links though not taken
        addStep(encI(opBeq, 5'd0, 5'd0, 16'hFFFD), 1'b0, 5'd0, 32'd0, curPc - 32'd8);
        // jumps
        addStep(encJ(opJ, 26'h0D00), 1'b0, 5'd0, 32'd0, 32'h0000_3400);
        addStep(encJ(opJal, 26'h0D40), 1'b1, 5'd31, curPc + 32'd4, 32'h0000_3500);
        addSeq(encI(opOri, 5'd0, 5'd20, 16'h3600), 1'b1, 5'd20, 32'h0000_3600);
        addStep(encR(fnJr, 5'd20, 5'd0, 5'd0, 5'd0), 1'b0, 5'd0, 32'd0, 32'h0000_3600);
        addSeq(encI(opOri, 5'd0, 5'd21, 16'h3700), 1'b1, 5'd21, 32'h0000_3700);
        addStep(encR(fnJalr, 5'd21, 5'd0, 5'd22, 5'd0), 1'b1, 5'd22, curPc + 32'd4,
                32'h0000_3700);
        addSeq(32'hFC00_0000, 1'b0, 5'd0, 32'd0); // opcode 0x3f, not decoded
        for (int n = 0; n < 16; n++) begin
            rnd = $urandom();
            rs  = rnd[6:2];
            rt  = rnd[11:7];
            rd  = rnd[16:12];
            imm = rnd[31:16];
            if (rnd[1:0] == 2'd0) begin
                addSeq(encI(opOri, rs, rt, imm), 1'b1, rt, model[rs] | {16'd0, imm});
            end else if (rnd[1:0] == 2'd1) begin
                addSeq(encI(opAddi, rs, rt, imm), 1'b1, rt, model[rs] + {{16{imm[15]}}, imm});
            end else begin
                addSeq(encR(fnXor, rs, rt, rd, 5'd0), 1'b1, rd, model[rs] ^ model[rt]);
            end
        end
    endtask

    initial begin
        rstN  = 1'b0;
        instr = encI(opLui, 5'd0, 5'd1, 16'hBEEF); // would write if not gated
        void'($urandom(20960));
        buildProgram();
        @(posedge clk);
        @(negedge clk);
        checkWord("pc", bootPc, pc);
        checkBit("wbEn", 1'b0, wbEn);
        foreach (prog[k]) begin
            @(posedge clk);
            rstN  <= 1'b1;
            instr <= prog[k].instr;
            @(negedge clk);
            checkWord("pc", prog[k].pc, pc);
            checkBit("wbEn", prog[k].en, wbEn);
            if (prog[k].en) begin
                checkReg("wbReg", prog[k].rg, wbReg);
                checkWord("wbData", prog[k].data, wbData);
            end
        end
        $display("Done: no errors");
        $finish;
    end

    initial begin
        #1;
        #((prog.size() + 10) * 100);
        $display("watchdog: run hung, no end after %0d cycles", prog.size() + 10);
        stopOnError();
    end

endmodule

// File: mipsCore.f
hw/mipsPkg.sv
hw/controller.sv
hw/regFile.sv
hw/alu.sv
hw/nextPc.sv
hw/dataMem.sv
hw/mipsCore.sv
bench/mipsCoreTb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --top-module mipsCoreTb -f mipsCore.f -o mipsCoreSim &&
./obj_dir/mipsCoreSim | grep "Done: no errors" &&
echo PASS || { echo FAIL; exit 1; }
